// File: Bender.yml
package:
  name: xbar

sources:
  - verilog/xbar_pkg.sv
  - verilog/xbar_rr_arbiter.sv
  - verilog/xbar_slave_port.sv
  - verilog/xbar_master_port.sv
  - verilog/xbar.sv
  - target: test
    files:
      - testbench/tb_xbar_slave_model.sv
      - testbench/tb_xbar.sv

// File: sim.f
verilog/xbar_pkg.sv
verilog/xbar_rr_arbiter.sv
verilog/xbar_slave_port.sv
verilog/xbar_master_port.sv
verilog/xbar.sv
testbench/tb_xbar_slave_model.sv
testbench/tb_xbar.sv

// File: testbench/tb_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xbar
	import xbar_pkg::*;
;

	localparam int NUM_ROWS = 12;
	localparam logic [ADDR_W-1:0] MAP_BASE [NUM_SLAVES] = '{32'h0000_0000, 32'h1000_0000};
	localparam logic [ADDR_W-1:0] MAP_END [NUM_SLAVES] = '{32'h0FFF_FFFF, 32'h1FFF_FFFF};

	// Paired means the next row joins the same test
	typedef struct packed {
		logic [MST_IDX_W-1:0] mst;
		logic [ID_W-1:0]      id;
		logic [ADDR_W-1:0]    addr;
		logic [LEN_W-1:0]     len;
		logic                 throttle;
		logic                 paired;
		logic [1:0]           resp;
	} row_t;

	logic                    aclk;
	logic                    arst_n;
	ar_m_t [NUM_MASTERS-1:0] mst_ar;
	logic [NUM_MASTERS-1:0]  mst_ar_valid;
	logic [NUM_MASTERS-1:0]  mst_ar_ready;
	r_m_t [NUM_MASTERS-1:0]  mst_r;
	logic [NUM_MASTERS-1:0]  mst_r_valid;
	logic [NUM_MASTERS-1:0]  mst_r_ready;
	ar_s_t [NUM_SLAVES-1:0]  slv_ar;
	logic [NUM_SLAVES-1:0]   slv_ar_valid;
	logic [NUM_SLAVES-1:0]   slv_ar_ready;
	r_s_t [NUM_SLAVES-1:0]   slv_r;
	logic [NUM_SLAVES-1:0]   slv_r_valid;
	logic [NUM_SLAVES-1:0]   slv_r_ready;

	row_t  rows [NUM_ROWS];
	r_m_t  exp_q [NUM_MASTERS][$];
	ar_s_t exp_ar_q [NUM_SLAVES][$];
	bit    rows_loaded = 1'b0;
	bit    throttle = 1'b0;
	int    err_cnt = 0;
	int    slv_ar_cnt = 0;
	int    tests_ok = 0;
	int    tests_bad = 0;

	xbar DUT (
		.aclk(aclk), .arst_n(arst_n),
		.mst_ar(mst_ar), .mst_ar_valid(mst_ar_valid), .mst_ar_ready(mst_ar_ready),
		.mst_r(mst_r), .mst_r_valid(mst_r_valid), .mst_r_ready(mst_r_ready),
		.slv_ar(slv_ar), .slv_ar_valid(slv_ar_valid), .slv_ar_ready(slv_ar_ready),
		.slv_r(slv_r), .slv_r_valid(slv_r_valid), .slv_r_ready(slv_r_ready)
	);

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
		tb_xbar_slave_model #(.SLV_IDX(s), .LATENCY(3)) u_model (
			.aclk(aclk), .arst_n(arst_n),
			.ar(slv_ar[s]), .ar_valid(slv_ar_valid[s]), .ar_ready(slv_ar_ready[s]),
			.r(slv_r[s]), .r_valid(slv_r_valid[s]), .r_ready(slv_r_ready[s])
		);
	end

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic load_rows();
		// mst, id, addr, len, throttle, paired, resp
		rows[0] = '{1'b0, 4'h3, 32'h0000_0100, 4'd0, 1'b0, 1'b0, RESP_OKAY};
		rows[1] = '{1'b0, 4'h5, 32'h1000_0200, 4'd0, 1'b0, 1'b0, RESP_OKAY};
		rows[2] = '{1'b1, 4'h7, 32'h0000_0300, 4'd0, 1'b0, 1'b0, RESP_OKAY};
		rows[3] = '{1'b1, 4'h9, 32'h1000_0400, 4'd0, 1'b0, 1'b0, RESP_OKAY};
		rows[4] = '{1'b0, 4'h2, 32'h1000_1000, 4'd3, 1'b0, 1'b0, RESP_OKAY};
		rows[5] = '{1'b0, 4'h1, 32'h0000_2000, 4'd3, 1'b0, 1'b1, RESP_OKAY};
		rows[6] = '{1'b1, 4'h6, 32'h0000_3000, 4'd3, 1'b0, 1'b0, RESP_OKAY};
		rows[7] = '{1'b1, 4'h4, 32'h3000_0000, 4'd2, 1'b0, 1'b0, RESP_DECERR};
		rows[8] = '{1'b0, 4'hA, 32'h0000_5000, 4'd2, 1'b1, 1'b1, RESP_OKAY};
		rows[9] = '{1'b0, 4'hB, 32'h1000_5000, 4'd1, 1'b1, 1'b1, RESP_OKAY};
		rows[10] = '{1'b1, 4'hC, 32'h1000_6000, 4'd3, 1'b1, 1'b1, RESP_OKAY};
		rows[11] = '{1'b1, 4'hD, 32'h0000_6000, 4'd2, 1'b1, 1'b0, RESP_OKAY};
	endtask

	function automatic int slave_of(logic [ADDR_W-1:0] addr);
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (addr >= MAP_BASE[s] && addr <= MAP_END[s]) begin
				return s;
			end
		end
		return -1;
	endfunction

	function automatic r_m_t expected_beat(row_t rw, int b);
		r_m_t              e;
		int                s;
		logic [ADDR_W-1:0] a;
		s = slave_of(rw.addr);
		a = rw.addr + ADDR_W'(4 * b);
		e.id = rw.id;
		e.resp = rw.resp;
		e.last = (b == int'(rw.len));
		e.data = (s < 0) ? '0 : (a ^ (ADDR_W'(s) * 32'hA5A5_0000));
		return e;
	endfunction

	function automatic int total_beats();
		int n;
		n = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			n += int'(rows[r].len) + 1;
		end
		return n;
	endfunction

	function automatic int pending_beats();
		int n;
		n = 0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			n += exp_q[m].size();
		end
		return n;
	endfunction

	task automatic report_mismatch(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
		$display("FAILED time %0t %s got %h expected %h", $time, name, got, exp);
		err_cnt++;
	endtask

	// Queue the expected beats as the request goes out
	task automatic drive_row(int r);
		int    m;
		int    s;
		ar_m_t a;
		ar_s_t sa;
		m = rows[r].mst;
		s = slave_of(rows[r].addr);
		a = '{id: rows[r].id, addr: rows[r].addr, len: rows[r].len,
			size: 3'd2, burst: 2'b01};
		mst_ar[m] <= a;
		mst_ar_valid[m] <= 1'b1;
		for (int b = 0; b <= int'(rows[r].len); b++) begin
			exp_q[m].push_back(expected_beat(rows[r], b));
		end
		// Mapped request reaches its slave with the master index above the ID
		if (s >= 0) begin
			sa = '{id: {MST_IDX_W'(m), a.id}, addr: a.addr, len: a.len,
				size: a.size, burst: a.burst};
			exp_ar_q[s].push_back(sa);
		end
	endtask

	task automatic run_test(int first, int last);
		int pend [NUM_MASTERS][$];
		int errs0;
		int ar0;
		int exp_ar;
		bit active;
		errs0 = err_cnt;
		ar0 = slv_ar_cnt;
		exp_ar = 0;
		for (int r = first; r <= last; r++) begin
			pend[rows[r].mst].push_back(r);
			if (slave_of(rows[r].addr) >= 0) begin
				exp_ar++;
			end
		end
		throttle <= rows[first].throttle;
		@(posedge aclk);
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (pend[m].size() != 0) begin
				drive_row(pend[m][0]);
			end
		end
		// Next row of a master follows its previous handshake
		do begin
			@(posedge aclk);
			active = 1'b0;
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (mst_ar_valid[m] && mst_ar_ready[m]) begin
					void'(pend[m].pop_front());
					if (pend[m].size() != 0) begin
						drive_row(pend[m][0]);
					end else begin
						mst_ar_valid[m] <= 1'b0;
					end
				end
				if (pend[m].size() != 0) begin
					active = 1'b1;
				end
			end
		end while (active);
		while (pending_beats() != 0) begin
			@(posedge aclk);
		end
		// Idle cycles so a stray extra beat still shows up
		repeat (8) @(posedge aclk);
		throttle <= 1'b0;
		if (slv_ar_cnt - ar0 != exp_ar) begin
			$display("FAILED time %0t slv_ar handshakes got %0d expected %0d",
				$time, slv_ar_cnt - ar0, exp_ar);
			err_cnt++;
		end
		if (err_cnt == errs0) begin
			tests_ok++;
			$display("test rows %0d to %0d: ok", first, last);
		end else begin
			tests_bad++;
			$display("test rows %0d to %0d: %0d errors", first, last, err_cnt - errs0);
		end
	endtask

	// R beat checker
	always @(posedge aclk) begin
		r_m_t e;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (arst_n && mst_r_valid[m] && mst_r_ready[m]) begin
				if (exp_q[m].size() == 0) begin
					$display("unexpected R beat on master %0d at time %0t", m, $time);
					err_cnt++;
				end else begin
					e = exp_q[m].pop_front();
					if (mst_r[m].id !== e.id)
						report_mismatch($sformatf("mst_r[%0d].id", m), mst_r[m].id, e.id);
					if (mst_r[m].data !== e.data)
						report_mismatch($sformatf("mst_r[%0d].data", m), mst_r[m].data, e.data);
					if (mst_r[m].resp !== e.resp)
						report_mismatch($sformatf("mst_r[%0d].resp", m), mst_r[m].resp, e.resp);
					if (mst_r[m].last !== e.last)
						report_mismatch($sformatf("mst_r[%0d].last", m), mst_r[m].last, e.last);
				end
			end
		end
	end

	// AR checker, arrival order between masters is left to the arbiter
	always @(posedge aclk) begin
		int k;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (slv_ar_valid[s] && slv_ar_ready[s]) begin
				slv_ar_cnt++;
				k = -1;
				for (int i = 0; i < exp_ar_q[s].size(); i++) begin
					if (k < 0 && exp_ar_q[s][i] === slv_ar[s]) begin
						k = i;
					end
				end
				if (k >= 0) begin
					exp_ar_q[s].delete(k);
				end else if (exp_ar_q[s].size() == 0) begin
					$display("slave %0d took AR %h with no request pending at time %0t",
						s, slv_ar[s], $time);
					err_cnt++;
				end else begin
					$display("FAILED time %0t slv_ar[%0d] got %h expected %h",
						$time, s, slv_ar[s], exp_ar_q[s][0]);
					err_cnt++;
				end
			end
		end
	end

	// R ready, randomly throttled during some tests
	initial begin
		void'($urandom(8145));
		mst_r_ready = '1;
		forever begin
			@(posedge aclk);
			for (int m = 0; m < NUM_MASTERS; m++) begin
				mst_r_ready[m] <= throttle ? 1'($urandom % 2) : 1'b1;
			end
		end
	end

	initial begin
		int limit;
		wait (rows_loaded);
		limit = total_beats() * 40 + 200;
		repeat (limit) @(posedge aclk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int r;
		int first;
		arst_n = 1'b0;
		mst_ar = '0;
		mst_ar_valid = '0;
		load_rows();
		rows_loaded = 1'b1;
		repeat (16) @(posedge aclk);
		arst_n <= 1'b1;
		@(posedge aclk);
		if (mst_ar_ready !== '1)
			report_mismatch("mst_ar_ready", mst_ar_ready, {NUM_MASTERS{1'b1}});
		if (mst_r_valid !== '0) report_mismatch("mst_r_valid", mst_r_valid, '0);
		if (slv_ar_valid !== '0) report_mismatch("slv_ar_valid", slv_ar_valid, '0);
		if (err_cnt == 0) begin
			tests_ok++;
			$display("test reset state: ok");
		end else begin
			tests_bad++;
			$display("test reset state: %0d errors", err_cnt);
		end
		r = 0;
		while (r < NUM_ROWS) begin
			first = r;
			while (rows[r].paired && r < NUM_ROWS - 1) begin
				r++;
			end
			run_test(first, r);
			r++;
		end
		$display("tests ok %0d, tests with errors %0d, errors %0d", tests_ok, tests_bad, err_cnt);
		if (err_cnt == 0 && tests_bad == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_xbar_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xbar_slave_model
	import xbar_pkg::*;
#(
	parameter int SLV_IDX = 0,
	parameter int LATENCY = 3
) (
	input  logic  aclk,
	input  logic  arst_n,
	input  ar_s_t ar,
	input  logic  ar_valid,
	output logic  ar_ready,
	output r_s_t  r,
	output logic  r_valid,
	input  logic  r_ready
);

	typedef enum logic [1:0] {S_IDLE, S_WAIT, S_SEND} state_t;

	state_t            state_q;
	ar_s_t             req_q;
	logic [LEN_W-1:0]  beat_q;
	int                wait_q;
	logic [ADDR_W-1:0] beat_addr;

	// One burst at a time
	assign ar_ready = (state_q == S_IDLE);
	assign r_valid = (state_q == S_SEND);
	assign beat_addr = req_q.addr + (ADDR_W'(beat_q) << 2);
	assign r = '{id: req_q.id, data: beat_addr ^ (ADDR_W'(SLV_IDX) * 32'hA5A5_0000),
		resp: RESP_OKAY, last: (beat_q == req_q.len)};

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= S_IDLE;
			req_q <= '0;
			beat_q <= '0;
			wait_q <= 0;
		end else begin
			case (state_q)
				S_IDLE: if (ar_valid) begin
					req_q <= ar;
					beat_q <= '0;
					wait_q <= LATENCY - 1;
					state_q <= S_WAIT;
				end
				// First beat comes LATENCY cycles after the AR handshake
				S_WAIT: if (wait_q == 0) begin
					state_q <= S_SEND;
				end else begin
					wait_q <= wait_q - 1;
				end
				S_SEND: if (r_ready) begin
					if (beat_q == req_q.len) begin
						state_q <= S_IDLE;
					end else begin
						beat_q <= beat_q + 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/xbar.sv
`timescale 1ns/1ps
`default_nettype none

module xbar
	import xbar_pkg::*;
#(
	parameter logic [NUM_SLAVES-1:0][ADDR_W-1:0] ADDR_BASE = {32'h1000_0000, 32'h0000_0000},
	parameter logic [NUM_SLAVES-1:0][ADDR_W-1:0] ADDR_END = {32'h1FFF_FFFF, 32'h0FFF_FFFF},
	parameter int MAX_OUTSTANDING = 4
) (
	input  logic                    aclk,
	input  logic                    arst_n,
	// Masters
	input  ar_m_t [NUM_MASTERS-1:0] mst_ar,
	input  logic [NUM_MASTERS-1:0]  mst_ar_valid,
	output logic [NUM_MASTERS-1:0]  mst_ar_ready,
	output r_m_t [NUM_MASTERS-1:0]  mst_r,
	output logic [NUM_MASTERS-1:0]  mst_r_valid,
	input  logic [NUM_MASTERS-1:0]  mst_r_ready,
	// Slaves
	output ar_s_t [NUM_SLAVES-1:0]  slv_ar,
	output logic [NUM_SLAVES-1:0]   slv_ar_valid,
	input  logic [NUM_SLAVES-1:0]   slv_ar_ready,
	input  r_s_t [NUM_SLAVES-1:0]   slv_r,
	input  logic [NUM_SLAVES-1:0]   slv_r_valid,
	output logic [NUM_SLAVES-1:0]   slv_r_ready
);

	// Seen from the master-facing ports, indexed [master][slave]
	ar_m_t [NUM_MASTERS-1:0]                 sp_ar_out;
	logic [NUM_MASTERS-1:0][NUM_SLAVES-1:0]  sp_ar_req;
	logic [NUM_MASTERS-1:0][NUM_SLAVES-1:0]  sp_ar_gnt;
	logic [NUM_MASTERS-1:0][NUM_SLAVES-1:0]  sp_r_req;
	logic [NUM_MASTERS-1:0][NUM_SLAVES-1:0]  sp_r_gnt;

	// Seen from the slave-facing ports, indexed [slave][master]
	r_m_t [NUM_SLAVES-1:0]                   mp_r_out;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]  mp_ar_req;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]  mp_ar_gnt;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]  mp_r_req;
	logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0]  mp_r_gnt;

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_slave_port
		xbar_slave_port #(
			.ADDR_BASE      (ADDR_BASE),
			.ADDR_END       (ADDR_END),
			.MAX_OUTSTANDING(MAX_OUTSTANDING)
		) u_slave_port (
			.aclk        (aclk),
			.arst_n      (arst_n),
			.mst_ar      (mst_ar[m]),
			.mst_ar_valid(mst_ar_valid[m]),
			.mst_ar_ready(mst_ar_ready[m]),
			.mst_r       (mst_r[m]),
			.mst_r_valid (mst_r_valid[m]),
			.mst_r_ready (mst_r_ready[m]),
			.ar_out      (sp_ar_out[m]),
			.ar_req      (sp_ar_req[m]),
			.ar_gnt      (sp_ar_gnt[m]),
			.r_in        (mp_r_out),
			.r_req       (sp_r_req[m]),
			.r_gnt       (sp_r_gnt[m])
		);
	end

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_master_port
		xbar_master_port u_master_port (
			.aclk        (aclk),
			.arst_n      (arst_n),
			.ar_in       (sp_ar_out),
			.ar_req      (mp_ar_req[s]),
			.ar_gnt      (mp_ar_gnt[s]),
			.slv_ar      (slv_ar[s]),
			.slv_ar_valid(slv_ar_valid[s]),
			.slv_ar_ready(slv_ar_ready[s]),
			.slv_r       (slv_r[s]),
			.slv_r_valid (slv_r_valid[s]),
			.slv_r_ready (slv_r_ready[s]),
			.r_out       (mp_r_out[s]),
			.r_req       (mp_r_req[s]),
			.r_gnt       (mp_r_gnt[s])
		);
	end

	// Request and grant vectors swap their two indices
	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_xpose_m
		for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_xpose_s
			assign mp_ar_req[s][m] = sp_ar_req[m][s];
			assign sp_ar_gnt[m][s] = mp_ar_gnt[s][m];
			assign sp_r_req[m][s] = mp_r_req[s][m];
			assign mp_r_gnt[s][m] = sp_r_gnt[m][s];
		end
	end

endmodule

`default_nettype wire

// File: verilog/xbar_master_port.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_master_port
	import xbar_pkg::*;
(
	input  logic                   aclk,
	input  logic                   arst_n,
	// Forward path
	input  ar_m_t [NUM_MASTERS-1:0] ar_in,
	input  logic [NUM_MASTERS-1:0]  ar_req,
	output logic [NUM_MASTERS-1:0]  ar_gnt,
	// Slave side
	output ar_s_t                   slv_ar,
	output logic                    slv_ar_valid,
	input  logic                    slv_ar_ready,
	input  r_s_t                    slv_r,
	input  logic                    slv_r_valid,
	output logic                    slv_r_ready,
	// Return path
	output r_m_t                    r_out,
	output logic [NUM_MASTERS-1:0]  r_req,
	input  logic [NUM_MASTERS-1:0]  r_gnt
);

	logic [NUM_MASTERS-1:0] arb_gnt;
	logic [NUM_MASTERS-1:0] win;
	logic                   can_load;
	logic                   load;
	logic                   ar_lock;
	ar_m_t                  sel_ar;
	logic [MST_IDX_W-1:0]   sel_idx;
	ar_s_t                  slv_ar_d;
	logic [MST_IDX_W-1:0]   r_dst;

	// Output register is free or emptying this cycle
	assign can_load = !slv_ar_valid || slv_ar_ready;
	assign ar_lock = slv_ar_valid && !slv_ar_ready;

	xbar_rr_arbiter #(
		.N(NUM_MASTERS)
	) u_ar_arb (
		.aclk   (aclk),
		.arst_n (arst_n),
		.req    (ar_req),
		.lock   (ar_lock),
		.advance(load),
		.gnt    (arb_gnt)
	);

	assign win = arb_gnt & ar_req;
	assign load = can_load && (|win);
	assign ar_gnt = can_load ? win : '0;

	always_comb begin
		sel_ar = '0;
		sel_idx = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (win[m]) begin
				sel_ar = ar_in[m];
				sel_idx = MST_IDX_W'(m);
			end
		end
	end

	// Master index goes on top of the ID
	always_comb begin
		slv_ar_d.id = {sel_idx, sel_ar.id};
		slv_ar_d.addr = sel_ar.addr;
		slv_ar_d.len = sel_ar.len;
		slv_ar_d.size = sel_ar.size;
		slv_ar_d.burst = sel_ar.burst;
	end

	always_ff @(posedge aclk) begin
		if (load) begin
			slv_ar <= slv_ar_d;
		end
	end

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			slv_ar_valid <= 1'b0;
		end else if (can_load) begin
			slv_ar_valid <= |win;
		end
	end

	// Return routing by the ID prefix
	assign r_dst = slv_r.id[IDS_W-1 -: MST_IDX_W];
	assign r_req = slv_r_valid ? (NUM_MASTERS'(1) << r_dst) : '0;
	assign r_out = '{id: slv_r.id[ID_W-1:0], data: slv_r.data, resp: slv_r.resp,
		last: slv_r.last};
	assign slv_r_ready = |(r_gnt & r_req);

endmodule

`default_nettype wire

// File: verilog/xbar_pkg.sv
`default_nettype none

package xbar_pkg;

	// Crossbar size
	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 2;
	localparam int MST_IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
	localparam int SLV_IDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

	// AXI field widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_W = 4;
	// Slave side carries the master index above the original ID
	localparam int IDS_W = ID_W + MST_IDX_W;
	localparam int LEN_W = 4;
	localparam int SIZE_W = 3;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// Read address, master side
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
		logic [SIZE_W-1:0] size;
		logic [1:0]        burst;
	} ar_m_t;

	// Read address, slave side
	typedef struct packed {
		logic [IDS_W-1:0]  id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
		logic [SIZE_W-1:0] size;
		logic [1:0]        burst;
	} ar_s_t;

	// Read data, master side
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} r_m_t;

	// Read data, slave side
	typedef struct packed {
		logic [IDS_W-1:0]  id;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} r_s_t;

endpackage

`default_nettype wire

// File: verilog/xbar_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_rr_arbiter #(
	parameter int N = 2
) (
	input  logic         aclk,
	input  logic         arst_n,
	input  logic [N-1:0] req,
	input  logic         lock,
	input  logic         advance,
	output logic [N-1:0] gnt
);

	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] gnt_idx;
	logic [N-1:0]     pick;
	logic [N-1:0]     hold_q;

	// Search starts one past the last winner
	always_comb begin
		int   idx;
		logic found;
		pick = '0;
		found = 1'b0;
		for (int o = 1; o <= N; o++) begin
			idx = (int'(last_q) + o) % N;
			if (!found && req[idx]) begin
				pick[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign gnt = lock ? hold_q : pick;

	always_comb begin
		gnt_idx = last_q;
		for (int i = 0; i < N; i++) begin
			if (gnt[i]) begin
				gnt_idx = IDX_W'(i);
			end
		end
	end

	// Reset value puts requester 0 first in line
	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			last_q <= IDX_W'(N - 1);
			hold_q <= '0;
		end else begin
			if (advance) begin
				last_q <= gnt_idx;
			end
			if (!lock) begin
				hold_q <= pick;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/xbar_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_slave_port
	import xbar_pkg::*;
#(
	parameter logic [NUM_SLAVES-1:0][ADDR_W-1:0] ADDR_BASE = {32'h1000_0000, 32'h0000_0000},
	parameter logic [NUM_SLAVES-1:0][ADDR_W-1:0] ADDR_END = {32'h1FFF_FFFF, 32'h0FFF_FFFF},
	parameter int MAX_OUTSTANDING = 4
) (
	input  logic                   aclk,
	input  logic                   arst_n,
	// Master side
	input  ar_m_t                  mst_ar,
	input  logic                   mst_ar_valid,
	output logic                   mst_ar_ready,
	output r_m_t                   mst_r,
	output logic                   mst_r_valid,
	input  logic                   mst_r_ready,
	// Forward path
	output ar_m_t                  ar_out,
	output logic [NUM_SLAVES-1:0]  ar_req,
	input  logic [NUM_SLAVES-1:0]  ar_gnt,
	// Return path
	input  r_m_t [NUM_SLAVES-1:0]  r_in,
	input  logic [NUM_SLAVES-1:0]  r_req,
	output logic [NUM_SLAVES-1:0]  r_gnt
);

	localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

	ar_m_t                 buf_q;
	logic                  full_q;
	logic [NUM_SLAVES-1:0] tgt_q;
	logic                  unmapped_q;
	logic [NUM_SLAVES-1:0] dec_tgt;

	logic [CNT_W-1:0]      cnt_q;
	logic [NUM_SLAVES-1:0] last_tgt_q;
	logic                  blocked;
	logic                  fwd;
	logic                  pop;

	logic [LEN_W-1:0]      de_beat_q;
	logic                  de_active;
	logic                  de_last;
	logic                  de_acc;
	r_m_t                  de_r;

	logic [NUM_SLAVES-1:0] r_arb_gnt;
	logic                  r_lock;
	logic                  burst_q;
	logic                  stall_q;
	r_m_t                  slv_r;
	logic                  slv_valid;
	logic                  slv_acc;

	// Address map lookup on the incoming request
	always_comb begin
		dec_tgt = '0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (mst_ar.addr >= ADDR_BASE[s] && mst_ar.addr <= ADDR_END[s]) begin
				dec_tgt[s] = 1'b1;
			end
		end
	end

	// Hold back on a full tracker or a change of target
	assign blocked = (cnt_q == CNT_W'(MAX_OUTSTANDING)) ||
		(cnt_q != '0 && tgt_q != last_tgt_q);
	assign ar_req = (full_q && !unmapped_q && !blocked) ? tgt_q : '0;
	assign ar_out = buf_q;
	assign fwd = |(ar_gnt & ar_req);

	// Unmapped reads wait until every earlier burst has drained
	assign de_active = full_q && unmapped_q && (cnt_q == '0);
	assign de_last = (de_beat_q == buf_q.len);
	assign de_acc = de_active && mst_r_ready;
	assign de_r = '{id: buf_q.id, data: '0, resp: RESP_DECERR, last: de_last};

	assign pop = fwd || (de_acc && de_last);
	assign mst_ar_ready = !full_q || pop;

	// Slave beat selection
	always_comb begin
		slv_r = '0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (r_arb_gnt[s]) begin
				slv_r = r_in[s];
			end
		end
	end

	assign slv_valid = |(r_arb_gnt & r_req);
	assign mst_r_valid = de_active ? 1'b1 : slv_valid;
	assign mst_r = de_active ? de_r : slv_r;
	assign r_gnt = (de_active || !mst_r_ready) ? '0 : (r_arb_gnt & r_req);
	assign slv_acc = |r_gnt;

	// Keep the chosen slave for a whole burst and across stalls
	assign r_lock = burst_q || stall_q;

	xbar_rr_arbiter #(
		.N(NUM_SLAVES)
	) u_r_arb (
		.aclk   (aclk),
		.arst_n (arst_n),
		.req    (r_req),
		.lock   (r_lock),
		.advance(slv_acc),
		.gnt    (r_arb_gnt)
	);

	always_ff @(posedge aclk) begin
		if (mst_ar_valid && mst_ar_ready) begin
			buf_q <= mst_ar;
			tgt_q <= dec_tgt;
			unmapped_q <= ~|dec_tgt;
		end
	end

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			full_q <= 1'b0;
			cnt_q <= '0;
			last_tgt_q <= '0;
			de_beat_q <= '0;
			burst_q <= 1'b0;
			stall_q <= 1'b0;
		end else begin
			if (mst_ar_valid && mst_ar_ready) begin
				full_q <= 1'b1;
			end else if (pop) begin
				full_q <= 1'b0;
			end
			// Outstanding bursts toward last_tgt_q
			if (fwd && !(slv_acc && slv_r.last)) begin
				cnt_q <= cnt_q + 1'b1;
			end else if (!fwd && slv_acc && slv_r.last) begin
				cnt_q <= cnt_q - 1'b1;
			end
			if (fwd) begin
				last_tgt_q <= tgt_q;
			end
			if (de_acc) begin
				de_beat_q <= de_last ? '0 : de_beat_q + 1'b1;
			end
			if (slv_acc) begin
				burst_q <= !slv_r.last;
			end
			stall_q <= slv_valid && !de_active && !mst_r_ready;
		end
	end

endmodule

`default_nettype wire
